/* Makefile */
# Verilator build for the falling-block display testbench

SIM       = verilator
TOP       = tetris_display_tb
FILELIST  = vlog.f
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* draw_board.sv */
// ****************************************
// two-stage pixel painter; stage 1 finds whether the
// pixel's cell holds a piece square, stage 2 picks the
// colour; sync and counts ride along with the decision
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module draw_board
  import tetris_pkg::*;
#(
  parameter int CELL_SHIFT = 5
) (
  input  wire         pclk,
  input  wire         rst_n,
  input  pixel_t      pix,
  input  squares_t    squares,
  input  wire  [11:0] piece_rgb,
  input  wire  [11:0] bg_rgb,
  output pixel_t      pix_out
);

  logic [10:0] cell_col;
  logic [10:0] cell_row;
  logic        hit;
  pixel_t      pix_s1;
  logic        hit_s1;

  assign cell_col = pix.hcount >> CELL_SHIFT;
  assign cell_row = pix.vcount >> CELL_SHIFT;

  // any of the four squares on this cell
  always_comb begin
    hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (cell_col == {6'd0, squares[i].col} && cell_row == {5'd0, squares[i].row})
        hit = 1'b1;
    end
  end

  // stage 1
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      pix_s1      <= '0;
      pix_s1.sync <= SYNC_IDLE;
      hit_s1      <= 1'b0;
    end else begin
      pix_s1 <= pix;
      hit_s1 <= hit;
    end
  end

  // stage 2, black in blanking
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      pix_out      <= '0;
      pix_out.sync <= SYNC_IDLE;
    end else begin
      pix_out.sync   <= pix_s1.sync;
      pix_out.hcount <= pix_s1.hcount;
      pix_out.vcount <= pix_s1.vcount;
      if (pix_s1.sync.blank)
        pix_out.rgb <= '0;
      else if (hit_s1)
        pix_out.rgb <= piece_rgb;
      else
        pix_out.rgb <= bg_rgb;
    end
  end

endmodule

`default_nettype wire

/* piece_regs.sv */
// ****************************************
// APB register file for the active piece, the background
// colour and a read-only frame counter; the piece is
// copied to frame_piece only at frame start
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module piece_regs
  import tetris_pkg::*;
(
  input  wire         pclk,
  input  wire         rst_n,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [3:0]  paddr,
  input  wire  [31:0] pwdata,
  input  wire         frame_start,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output piece_t      frame_piece,
  output logic [11:0] bg_rgb
);

  piece_t      piece_q;
  logic [31:0] frame_cnt;
  logic        setup;
  logic        access;
  logic        addr_ok;

  assign setup   = psel && !penable;
  assign access  = psel && penable;
  assign addr_ok = (paddr == ADDR_PIECE) || (paddr == ADDR_BG) || (paddr == ADDR_FRAME);

  // no wait states
  assign pready = 1'b1;

  // response is decoded in the setup phase, held for access
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else begin
      prdata  <= '0;
      pslverr <= setup && (!addr_ok || (pwrite && paddr == ADDR_FRAME));
      if (setup && !pwrite) begin
        case (paddr)
          ADDR_PIECE: prdata <= {18'd0, piece_q};
          ADDR_BG:    prdata <= {20'd0, bg_rgb};
          ADDR_FRAME: prdata <= frame_cnt;
          default:    prdata <= '0;
        endcase
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      piece_q     <= '0;
      bg_rgb      <= '0;
      frame_cnt   <= '0;
      frame_piece <= '0;
    end else begin
      if (access && pwrite && paddr == ADDR_PIECE)
        piece_q <= piece_t'(pwdata[13:0]);
      if (access && pwrite && paddr == ADDR_BG)
        bg_rgb <= pwdata[11:0];
      // frame counter ignores writes
      if (frame_start) begin
        frame_cnt   <= frame_cnt + 32'd1;
        frame_piece <= piece_q;
      end
    end
  end

endmodule

`default_nettype wire

/* piece_shape.sv */
// ****************************************
// expands the frame piece into four absolute board
// squares and its colour, one register stage
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module piece_shape
  import tetris_pkg::*;
(
  input  wire         pclk,
  input  wire         rst_n,
  input  piece_t      frame_piece,
  output squares_t    squares,
  output logic [11:0] piece_rgb
);

  offsets_t offs;
  squares_t squares_d;

  assign offs = shape_offsets(frame_piece.shape, frame_piece.rot);

  // origin plus offset, widened so edge overflow is kept
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      squares_d[i].col = {1'b0, frame_piece.col} + {3'd0, offs[i].col};
      squares_d[i].row = {1'b0, frame_piece.row} + {4'd0, offs[i].row};
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      squares   <= '0;
      piece_rgb <= '0;
    end else begin
      squares   <= squares_d;
      piece_rgb <= shape_color(frame_piece.shape);
    end
  end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// ****************************************
// testbench clock and reset source; free-running pclk
// and an active-low reset held for a fixed cycle count
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic pclk,
  output logic rst_n
);

  initial begin
    pclk = 1'b0;
    forever #(PERIOD_NS / 2) pclk = ~pclk;
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge pclk);
    @(negedge pclk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tetris_display_properties.sv */
// ****************************************
// concurrent checks on the APB response and the VGA
// pins, bound into the display top level
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tetris_display_properties (
  input wire       pclk,
  input wire       rst_n,
  input wire       psel,
  input wire       penable,
  input wire       pready,
  input wire       pslverr,
  input wire       hs,
  input wire       blank,
  input wire [3:0] r,
  input wire [3:0] g,
  input wire [3:0] b
);

  int unsigned failures = 0;

  // no wait states ever
  pready_high: assert property (@(posedge pclk) disable iff (!rst_n) pready)
    else begin
      $error("pready dropped low");
      failures++;
    end

  slverr_in_access: assert property (@(posedge pclk) disable iff (!rst_n)
    pslverr |-> (psel && penable))
    else begin
      $error("pslverr outside an access phase");
      failures++;
    end

  black_in_blank: assert property (@(posedge pclk) disable iff (!rst_n)
    blank |-> ({r, g, b} == 12'h000))
    else begin
      $error("colour driven during blanking");
      failures++;
    end

  // hsync sits inside the horizontal blanking
  hsync_in_blank: assert property (@(posedge pclk) disable iff (!rst_n) !hs |-> blank)
    else begin
      $error("hsync active outside blanking");
      failures++;
    end

endmodule

bind tetris_display_top tetris_display_properties props_inst (
  .pclk    (pclk),
  .rst_n   (rst_n),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .hs      (hs),
  .blank   (blank),
  .r       (r),
  .g       (g),
  .b       (b)
);

`default_nettype wire

/* tetris_display_tb.sv */
// ****************************************
// table-driven testbench for the display top level; APB
// register tests, per-pixel frame checks against a model
// of the sweep, mid-frame piece writes and frame counting
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tetris_display_tb
  import tetris_pkg::*;
;

  // tiny screen
  localparam int H_ACTIVE     = 64;
  localparam int H_FP         = 4;
  localparam int H_SYNC       = 8;
  localparam int H_BP         = 4;
  localparam int V_ACTIVE     = 48;
  localparam int V_FP         = 2;
  localparam int V_SYNC       = 2;
  localparam int V_BP         = 4;
  localparam int CELL_SHIFT   = 2;
  localparam int H_TOTAL      = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL      = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int H_SYNC_START = H_ACTIVE + H_FP;
  localparam int V_SYNC_START = V_ACTIVE + V_FP;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int RESET_CYCLES = 10;

  typedef enum logic [2:0] {
    ACT_IDLE, ACT_READ, ACT_WRITE, ACT_FRAME_WR, ACT_DRAW, ACT_RAND, ACT_MID, ACT_COUNT
  } act_t;

  typedef struct packed {
    act_t        act;
    logic [3:0]  addr;
    logic [31:0] data;
    logic [31:0] exp_data;
    logic        exp_err;
    piece_t      piece;
    logic [11:0] bg;
  } test_t;

  logic        pclk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        hs;
  logic        vs;
  logic        blank;
  logic [3:0]  r;
  logic [3:0]  g;
  logic [3:0]  b;

  test_t       tests[$];
  string       names[$];
  int          errors = 0;
  int          test_prints = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  int          limit = 0;
  int          vs_pulses = 0;
  logic        vs_last = 1'b1;
  logic [31:0] lfsr;
  piece_t      cur_piece = '0;
  logic [11:0] cur_bg = '0;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) clock_gen_inst (
    .pclk  (pclk),
    .rst_n (rst_n)
  );

  tetris_display_top #(
    .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
    .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP),
    .CELL_SHIFT (CELL_SHIFT)
  ) tetris_display_top_inst (
    .pclk (pclk), .rst_n (rst_n), .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata), .pready (pready),
    .pslverr (pslverr), .hs (hs), .vs (vs), .blank (blank), .r (r), .g (g), .b (b)
  );

  always @(posedge pclk) cycles <= cycles + 1;

  // completed vsync pulses seen at the pins
  always @(negedge pclk) begin
    if (rst_n && !vs_last && vs)
      vs_pulses <= vs_pulses + 1;
    vs_last <= vs;
  end

  function automatic piece_t pc(input logic [3:0] c, input logic [4:0] rw,
                                input logic [2:0] s, input logic [1:0] rt);
    return '{col: c, row: rw, shape: s, rot: rt};
  endfunction

  // galois form, taps x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic logic [11:0] predict_rgb(input int h, input int v, input piece_t p,
                                              input logic [11:0] bg);
    offsets_t offs;
    int       cc;
    int       cr;
    logic     hit;
    if (h >= H_ACTIVE || v >= V_ACTIVE)
      return 12'h000;
    offs = shape_offsets(p.shape, p.rot);
    hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      cc = int'(p.col) + int'(offs[i].col);
      cr = int'(p.row) + int'(offs[i].row);
      if ((h >> CELL_SHIFT) == cc && (v >> CELL_SHIFT) == cr)
        hit = 1'b1;
    end
    return hit ? shape_color(p.shape) : bg;
  endfunction

  task automatic add_test(input string name, input act_t act, input logic [3:0] addr,
                          input logic [31:0] data, input logic [31:0] exp_data,
                          input logic exp_err, input piece_t p, input logic [11:0] bg);
    tests.push_back('{act: act, addr: addr, data: data, exp_data: exp_data,
                      exp_err: exp_err, piece: p, bg: bg});
    names.push_back(name);
  endtask

  task automatic build_table();
    add_test("reset_sync", ACT_IDLE, 4'h0, 0, 0, 1'b0, '0, 12'h0);
    add_test("rst_piece", ACT_READ, ADDR_PIECE, 0, 0, 1'b0, '0, 12'h0);
    add_test("rst_bg", ACT_READ, ADDR_BG, 0, 0, 1'b0, '0, 12'h0);
    // first frame starts on the first cycle out of reset
    add_test("rst_frame", ACT_READ, ADDR_FRAME, 0, 1, 1'b0, '0, 12'h0);
    add_test("wr_piece", ACT_WRITE, ADDR_PIECE, {18'd0, pc(9, 17, 6, 3)}, 0, 1'b0, '0, 12'h0);
    add_test("rd_piece", ACT_READ, ADDR_PIECE, 0, {18'd0, pc(9, 17, 6, 3)}, 1'b0, '0, 12'h0);
    add_test("wr_bg", ACT_WRITE, ADDR_BG, 32'hFFFF_FABC, 0, 1'b0, '0, 12'h0);
    add_test("rd_bg", ACT_READ, ADDR_BG, 0, 32'h0000_0ABC, 1'b0, '0, 12'h0);
    add_test("bad_rd", ACT_READ, 4'hC, 0, 0, 1'b1, '0, 12'h0);
    add_test("bad_wr", ACT_WRITE, 4'h2, 32'h1234, 0, 1'b1, '0, 12'h0);
    add_test("frame_wr", ACT_FRAME_WR, ADDR_FRAME, 0, 0, 1'b1, '0, 12'h0);
    add_test("draw_i", ACT_DRAW, 4'h0, 0, 0, 1'b0, pc(2, 1, 0, 0), 12'h123);
    add_test("draw_o", ACT_DRAW, 4'h0, 0, 0, 1'b0, pc(7, 5, 1, 0), 12'h234);
    add_test("draw_t", ACT_DRAW, 4'h0, 0, 0, 1'b0, pc(10, 3, 2, 1), 12'h345);
    add_test("draw_s", ACT_DRAW, 4'h0, 0, 0, 1'b0, pc(0, 8, 3, 2), 12'h456);
    add_test("draw_z", ACT_DRAW, 4'h0, 0, 0, 1'b0, pc(12, 0, 4, 3), 12'h567);
    add_test("draw_j", ACT_DRAW, 4'h0, 0, 0, 1'b0, pc(5, 9, 5, 1), 12'h678);
    add_test("draw_edge", ACT_DRAW, 4'h0, 0, 0, 1'b0, pc(14, 10, 6, 3), 12'h789);
    add_test("rand_a", ACT_RAND, 4'h0, 0, 0, 1'b0, '0, 12'h0);
    add_test("rand_b", ACT_RAND, 4'h0, 0, 0, 1'b0, '0, 12'h0);
    add_test("mid_frame", ACT_MID, 4'h0, 0, 0, 1'b0, pc(3, 4, 2, 2), 12'h0);
    add_test("frame_count", ACT_COUNT, 4'h0, 0, 0, 1'b0, '0, 12'h0);
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    if (test_prints < 8)
      $display("[FAIL] %s: expected 'h%0h, actual 'h%0h", what, expected, actual);
    test_prints++;
  endtask

  // call on a falling edge, returns on a falling edge
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge pclk);
    penable = 1'b1;
    rdata   = prdata;
    err     = pslverr;
    if (pready !== 1'b1)
      report_mismatch("pready in access", 32'd1, 32'(pready));
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic wait_vs_edge(input logic level);
    logic last;
    last = vs;
    @(negedge pclk);
    while (!(last !== level && vs === level)) begin
      last = vs;
      @(negedge pclk);
    end
  endtask

  // starts on the first pin cycle with vsync low, i.e. (0, V_SYNC_START)
  task automatic check_frame(input string name, input piece_t p, input logic [11:0] bg);
    int          h;
    int          v;
    logic [11:0] exp_rgb;
    sync_t       exp_sync;
    h = 0;
    v = V_SYNC_START;
    repeat (FRAME_CYCLES) begin
      exp_rgb = predict_rgb(h, v, p, bg);
      exp_sync.hsync = !(h >= H_SYNC_START && h < H_SYNC_START + H_SYNC);
      exp_sync.vsync = !(v >= V_SYNC_START && v < V_SYNC_START + V_SYNC);
      exp_sync.blank = (h >= H_ACTIVE) || (v >= V_ACTIVE);
      if ({r, g, b} !== exp_rgb)
        report_mismatch($sformatf("%s rgb at (%0d,%0d)", name, h, v),
                        32'(exp_rgb), 32'({r, g, b}));
      if ({hs, vs, blank} !== exp_sync)
        report_mismatch($sformatf("%s sync at (%0d,%0d)", name, h, v),
                        32'(exp_sync), 32'({hs, vs, blank}));
      h = (h == H_TOTAL - 1) ? 0 : h + 1;
      if (h == 0)
        v = (v == V_TOTAL - 1) ? 0 : v + 1;
      @(negedge pclk);
    end
  endtask

  task automatic run_test(input int idx);
    test_t       t;
    string       name;
    piece_t      p;
    logic [11:0] bg;
    logic [31:0] rd;
    logic [31:0] rd2;
    logic        err;
    int          start_errs;
    int          pulses_a;
    t = tests[idx];
    name = names[idx];
    start_errs = errors;
    test_prints = 0;
    case (t.act)
      ACT_IDLE: begin
        if ({hs, vs} !== 2'b11)
          report_mismatch({name, " hs/vs"}, 32'h3, 32'({hs, vs}));
      end
      ACT_READ: begin
        apb_xfer(1'b0, t.addr, '0, rd, err);
        if (rd !== t.exp_data)
          report_mismatch({name, " prdata"}, t.exp_data, rd);
        if (err !== t.exp_err)
          report_mismatch({name, " pslverr"}, 32'(t.exp_err), 32'(err));
      end
      ACT_WRITE: begin
        apb_xfer(1'b1, t.addr, t.data, rd, err);
        if (err !== t.exp_err)
          report_mismatch({name, " pslverr"}, 32'(t.exp_err), 32'(err));
        if (!t.exp_err && t.addr == ADDR_PIECE)
          cur_piece = piece_t'(t.data[13:0]);
        if (!t.exp_err && t.addr == ADDR_BG)
          cur_bg = t.data[11:0];
      end
      ACT_FRAME_WR: begin
        // far from the next frame start
        wait_vs_edge(1'b1);
        apb_xfer(1'b0, ADDR_FRAME, '0, rd, err);
        apb_xfer(1'b1, ADDR_FRAME, 32'h0000_0040, rd2, err);
        if (err !== 1'b1)
          report_mismatch({name, " pslverr"}, 32'd1, 32'(err));
        apb_xfer(1'b0, ADDR_FRAME, '0, rd2, err);
        if (rd2 !== rd)
          report_mismatch({name, " counter"}, rd, rd2);
      end
      ACT_DRAW, ACT_RAND: begin
        p = t.piece;
        bg = t.bg;
        if (t.act == ACT_RAND) begin
          p.col = 4'(take_bits(4));
          p.row = 5'(take_bits(4));
          p.shape = 3'(take_bits(3) % 7);
          p.rot = 2'(take_bits(2));
          bg = 12'(take_bits(12));
        end
        apb_xfer(1'b1, ADDR_PIECE, {18'd0, p}, rd, err);
        if (err !== 1'b0)
          report_mismatch({name, " pslverr"}, 32'd0, 32'(err));
        apb_xfer(1'b1, ADDR_BG, {20'd0, bg}, rd, err);
        repeat (2) wait_vs_edge(1'b0);
        check_frame(name, p, bg);
        cur_piece = p;
        cur_bg = bg;
      end
      ACT_MID: begin
        wait_vs_edge(1'b0);
        fork
          check_frame(name, cur_piece, cur_bg);
          begin
            // line 20 of the active area
            repeat (H_TOTAL * (V_TOTAL - V_SYNC_START + 20)) @(negedge pclk);
            apb_xfer(1'b1, ADDR_PIECE, {18'd0, t.piece}, rd, err);
          end
        join
        if (err !== 1'b0)
          report_mismatch({name, " pslverr"}, 32'd0, 32'(err));
        check_frame(name, t.piece, cur_bg);
        cur_piece = t.piece;
      end
      ACT_COUNT: begin
        wait_vs_edge(1'b1);
        apb_xfer(1'b0, ADDR_FRAME, '0, rd, err);
        pulses_a = vs_pulses;
        repeat (2) wait_vs_edge(1'b1);
        apb_xfer(1'b0, ADDR_FRAME, '0, rd2, err);
        if (rd2 - rd !== 32'(vs_pulses - pulses_a))
          report_mismatch({name, " frames"}, 32'(vs_pulses - pulses_a), rd2 - rd);
      end
    endcase
    if (errors == start_errs) begin
      $display("test %0d %s: ok", idx, name);
    end else begin
      $display("test %0d %s: %0d errors", idx, name, errors - start_errs);
      tests_failed++;
    end
  endtask

  initial begin
    wait (limit > 0);
    wait (cycles >= limit);
    $display("timeout: run exceeded %0d cycles before the tests finished", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int asrt;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    lfsr    = 32'h04c3_cd90;
    build_table();
    limit = tests.size() * 3 * FRAME_CYCLES + RESET_CYCLES;
    wait (rst_n === 1'b1);
    @(negedge pclk);
    for (int i = 0; i < tests.size(); i++)
      run_test(i);
    asrt = int'(tetris_display_top_inst.props_inst.failures);
    $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests.size(), tests_failed, errors, asrt);
    if (errors == 0 && tests_failed == 0 && asrt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tetris_display_top.sv */
// ****************************************
// display top level; sweep, APB piece registers, shape
// expansion and painter, with registered VGA pins
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tetris_display_top
  import tetris_pkg::*;
#(
  parameter int H_ACTIVE   = 640,
  parameter int H_FP       = 16,
  parameter int H_SYNC     = 96,
  parameter int H_BP       = 48,
  parameter int V_ACTIVE   = 480,
  parameter int V_FP       = 10,
  parameter int V_SYNC     = 2,
  parameter int V_BP       = 33,
  parameter int CELL_SHIFT = 5
) (
  input  wire         pclk,
  input  wire         rst_n,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [3:0]  paddr,
  input  wire  [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        hs,
  output logic        vs,
  output logic        blank,
  output logic [3:0]  r,
  output logic [3:0]  g,
  output logic [3:0]  b
);

  pixel_t      pix;
  pixel_t      pix_out;
  logic        frame_start;
  piece_t      frame_piece;
  logic [11:0] bg_rgb;
  squares_t    squares;
  logic [11:0] piece_rgb;

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) vga_timing_inst (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .pix         (pix),
    .frame_start (frame_start)
  );

  piece_regs piece_regs_inst (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .frame_start (frame_start),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .frame_piece (frame_piece),
    .bg_rgb      (bg_rgb)
  );

  piece_shape piece_shape_inst (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .frame_piece (frame_piece),
    .squares     (squares),
    .piece_rgb   (piece_rgb)
  );

  draw_board #(
    .CELL_SHIFT (CELL_SHIFT)
  ) draw_board_inst (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .pix       (pix),
    .squares   (squares),
    .piece_rgb (piece_rgb),
    .bg_rgb    (bg_rgb),
    .pix_out   (pix_out)
  );

  // output pins, third pipeline cycle
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      hs      <= SYNC_IDLE.hsync;
      vs      <= SYNC_IDLE.vsync;
      blank   <= SYNC_IDLE.blank;
      {r, g, b} <= '0;
    end else begin
      hs      <= pix_out.sync.hsync;
      vs      <= pix_out.sync.vsync;
      blank   <= pix_out.sync.blank;
      {r, g, b} <= pix_out.rgb;
    end
  end

endmodule

`default_nettype wire

/* tetris_pkg.sv */
// ****************************************
// shared types, register map and shape tables for the
// falling-block display; every design file imports this
// package, and the testbench uses it to predict pixels
// ****************************************
`default_nettype none

package tetris_pkg;

  // active piece as held in the piece register
  typedef struct packed {
    logic [3:0] col;
    logic [4:0] row;
    logic [2:0] shape;
    logic [1:0] rot;
  } piece_t;

  // one occupied square, a bit wider than the board fields
  typedef struct packed {
    logic [4:0] col;
    logic [5:0] row;
  } square_t;

  typedef square_t [3:0] squares_t;

  // offset of one square inside the 4x4 shape box
  typedef struct packed {
    logic [1:0] col;
    logic [1:0] row;
  } offset_t;

  typedef offset_t [3:0] offsets_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic blank;
  } sync_t;

  typedef struct packed {
    sync_t       sync;
    logic [10:0] hcount;
    logic [10:0] vcount;
    logic [11:0] rgb;
  } pixel_t;

  // syncs inactive, blanked
  localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, blank: 1'b1};

  localparam logic [3:0] ADDR_PIECE = 4'h0;
  localparam logic [3:0] ADDR_BG    = 4'h4;
  localparam logic [3:0] ADDR_FRAME = 4'h8;

  // base shapes at rotation 0, one nibble {col, row} per square
  function automatic offsets_t shape_offsets(input logic [2:0] shape, input logic [1:0] rot);
    offsets_t base;
    offsets_t turned;
    case (shape)
      3'd0:    base = offsets_t'(16'h159D);  // I
      3'd1:    base = offsets_t'(16'h4859);  // O
      3'd2:    base = offsets_t'(16'h1594);  // T
      3'd3:    base = offsets_t'(16'h4815);  // S
      3'd4:    base = offsets_t'(16'h0459);  // Z
      3'd5:    base = offsets_t'(16'h0159);  // J
      3'd6:    base = offsets_t'(16'h8159);  // L
      default: base = offsets_t'(16'h4859);
    endcase
    // quarter turns clockwise inside the 4x4 box
    for (int k = 0; k < 3; k++) begin
      if (k < int'(rot)) begin
        for (int i = 0; i < 4; i++) begin
          turned[i].col = 2'd3 - base[i].row;
          turned[i].row = base[i].col;
        end
        base = turned;
      end
    end
    return base;
  endfunction

  function automatic logic [11:0] shape_color(input logic [2:0] shape);
    case (shape)
      3'd0:    return 12'h0FF;
      3'd1:    return 12'hFF0;
      3'd2:    return 12'hA0F;
      3'd3:    return 12'h0F0;
      3'd4:    return 12'hF00;
      3'd5:    return 12'h00F;
      3'd6:    return 12'hF80;
      default: return 12'hFFF;
    endcase
  endfunction

endpackage

`default_nettype wire

/* vga_timing.sv */
// ****************************************
// screen sweep generator; counts pixels and lines over
// the full frame and derives blanking, active-low syncs
// and a frame start strobe from the interval parameters
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module vga_timing
  import tetris_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FP     = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BP     = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP     = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 33
) (
  input  wire    pclk,
  input  wire    rst_n,
  output pixel_t pix,
  output logic   frame_start
);

  localparam logic [10:0] H_LAST       = 11'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
  localparam logic [10:0] V_LAST       = 11'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);
  localparam logic [10:0] H_SYNC_START = 11'(H_ACTIVE + H_FP);
  localparam logic [10:0] H_SYNC_END   = 11'(H_ACTIVE + H_FP + H_SYNC);
  localparam logic [10:0] V_SYNC_START = 11'(V_ACTIVE + V_FP);
  localparam logic [10:0] V_SYNC_END   = 11'(V_ACTIVE + V_FP + V_SYNC);

  logic [10:0] hcount;
  logic [10:0] vcount;

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      hcount <= '0;
      vcount <= '0;
    end else if (hcount == H_LAST) begin
      hcount <= '0;
      // end of line, step to next line or wrap the frame
      vcount <= (vcount == V_LAST) ? '0 : vcount + 11'd1;
    end else begin
      hcount <= hcount + 11'd1;
    end
  end

  always_comb begin
    pix.hcount     = hcount;
    pix.vcount     = vcount;
    pix.rgb        = '0;
    pix.sync.blank = (hcount >= 11'(H_ACTIVE)) || (vcount >= 11'(V_ACTIVE));
    pix.sync.hsync = !((hcount >= H_SYNC_START) && (hcount < H_SYNC_END));
    pix.sync.vsync = !((vcount >= V_SYNC_START) && (vcount < V_SYNC_END));
  end

  assign frame_start = (hcount == '0) && (vcount == '0);

endmodule

`default_nettype wire

/* vlog.f */
tetris_pkg.sv
vga_timing.sv
piece_regs.sv
piece_shape.sv
draw_board.sv
tetris_display_top.sv
tetris_display_properties.sv
tb_clock_gen.sv
tetris_display_tb.sv
